/* vlog.f */
+incdir+sim
hdl/rv32i_pkg.sv
hdl/ctrl_pkg.sv
hdl/stall_ctrl.sv
hdl/instr_decoder.sv
hdl/cw_pipe.sv
hdl/pipe_ctrl_top.sv
sim/tb_pipe_ctrl.sv

/* Makefile */
# Verilator build and run of the pipeline control unit testbench

SRCS = hdl/rv32i_pkg.sv hdl/ctrl_pkg.sv hdl/stall_ctrl.sv hdl/instr_decoder.sv \
       hdl/cw_pipe.sv hdl/pipe_ctrl_top.sv sim/ctrl_model.svh sim/tb_pipe_ctrl.sv

.PHONY: all run clean

all: obj_dir/Vtb_pipe_ctrl

# rebuilt only when a source or the file list changes
obj_dir/Vtb_pipe_ctrl: vlog.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_pipe_ctrl -f vlog.f

# exit status of the simulator is the test result
run: obj_dir/Vtb_pipe_ctrl
	./obj_dir/Vtb_pipe_ctrl

clean:
	rm -rf obj_dir

/* sim/ctrl_model.svh */
// reference model for the pipeline control unit
// decode from the rv32i field rules, load enables, bubble flags, next-pc select

`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// control word from opcode, funct3, funct7
function automatic ctrl_word_t model_decode(input opcode_t op, input logic [2:0] f3,
                                            input logic [6:0] f7);
    ctrl_word_t cw;
    cw = CW_DEFAULT;
    case (op)
        op_lui: begin
            cw.wb.ld_reg         = 1'b1;
            cw.wb.regfilemux_sel = regfilemux_u_imm;
        end
        op_auipc: begin
            cw.exe.alumux1_sel = alumux1_pc_out;
            cw.exe.alumux2_sel = alumux2_u_imm;
            cw.wb.ld_reg       = 1'b1;
        end
        op_jal, op_jalr: begin
            // both link pc+4
            cw.wb.ld_reg         = 1'b1;
            cw.wb.regfilemux_sel = regfilemux_pc_plus4;
            if (op == op_jal) begin
                cw.exe.alumux1_sel = alumux1_pc_out;
                cw.exe.alumux2_sel = alumux2_j_imm;
                cw.pc_kind         = pc_jump;
            end else begin
                cw.pc_kind = pc_jump_reg;
            end
        end
        op_br: begin
            cw.exe.alumux1_sel = alumux1_pc_out;
            cw.exe.alumux2_sel = alumux2_b_imm;
            cw.exe.cmpop       = branch_funct3_t'(f3);
            cw.pc_kind         = pc_branch;
        end
        op_load: begin
            cw.mem.mem_read = 1'b1;
            cw.wb.ld_reg    = 1'b1;
            // lb lh lw lbu lhu, anything else is reserved
            case (f3)
                3'b000:  cw.wb.regfilemux_sel = regfilemux_lb;
                3'b001:  cw.wb.regfilemux_sel = regfilemux_lh;
                3'b010:  cw.wb.regfilemux_sel = regfilemux_lw;
                3'b100:  cw.wb.regfilemux_sel = regfilemux_lbu;
                3'b101:  cw.wb.regfilemux_sel = regfilemux_lhu;
                default: cw = CW_DEFAULT;
            endcase
        end
        op_store: begin
            cw.exe.alumux2_sel = alumux2_s_imm;
            cw.mem.mem_write   = 1'b1;
        end
        op_imm, op_reg: begin
            cw.wb.ld_reg       = 1'b1;
            cw.exe.alumux2_sel = (op == op_reg) ? alumux2_rs2_out : alumux2_i_imm;
            cw.exe.cmp_sel     = (op == op_reg) ? cmpmux_rs2_out : cmpmux_i_imm;
            case (f3)
                // only the register form has sub
                3'b000: cw.exe.aluop = (op == op_reg && f7[FUNCT7_ALT_BIT]) ? alu_sub : alu_add;
                3'b001: cw.exe.aluop = alu_sll;
                3'b010: begin
                    cw.exe.cmpop         = blt;
                    cw.wb.regfilemux_sel = regfilemux_br_en;
                end
                3'b011: begin
                    cw.exe.cmpop         = bltu;
                    cw.wb.regfilemux_sel = regfilemux_br_en;
                end
                3'b100: cw.exe.aluop = alu_xor;
                3'b101: cw.exe.aluop = f7[FUNCT7_ALT_BIT] ? alu_sra : alu_srl;
                3'b110: cw.exe.aluop = alu_or;
                default: cw.exe.aluop = alu_and;
            endcase
        end
        // illegal opcode stays a nop
        default: cw = CW_DEFAULT;
    endcase
    return cw;
endfunction

// register k feeds stage k, frozen by any stall from k down to wb
function automatic preg_vec_t model_ld(input logic in_rst, input stage_vec_t valid,
                                       input stage_vec_t ready);
    preg_vec_t ld;
    ld = '0;
    if (!in_rst) begin
        for (int j = 0; j < N_PREGS; j++) begin
            ld[j] = 1'b1;
            for (int s = 0; s <= j; s++) begin
                if (valid[s] && !ready[s]) begin
                    ld[j] = 1'b0;
                end
            end
        end
    end
    return ld;
endfunction

// feeding stage hands on a word only when valid and ready
function automatic preg_vec_t model_bubble(input stage_vec_t valid, input stage_vec_t ready);
    preg_vec_t bub;
    for (int j = 0; j < N_PREGS; j++) begin
        bub[j] = !(valid[j+1] && ready[j+1]);
    end
    return bub;
endfunction

function automatic pcmux_sel_t model_pcsel(input pc_kind_t kind, input logic br);
    pcmux_sel_t sel;
    case (kind)
        pc_jump:     sel = pcmux_alu_out;
        pc_jump_reg: sel = pcmux_alu_mod2;
        pc_branch:   sel = br ? pcmux_alu_out : pcmux_pc_plus4;
        default:     sel = pcmux_pc_plus4;
    endcase
    return sel;
endfunction

`endif

/* sim/tb_pipe_ctrl.sv */
// testbench for the pipeline control unit
// xorshift stimulus, mirrored control-word registers, per-cycle checks, watchdog

`timescale 1ns/1ps

module tb_pipe_ctrl import rv32i_pkg::*, ctrl_pkg::*; ();

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          N_CYCLES     = 4000;
    // test length plus reset plus some slack
    localparam int          WATCHDOG_NS  = (RESET_CYCLES + N_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'h24663b46;

    logic                clk;
    logic                rst;
    stage_vec_t          stage_valid;
    stage_vec_t          stage_ready;
    opcode_t             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic                br_en;
    preg_vec_t           ld;
    cw_exe_t             cw_exe;
    cw_mem_t             cw_mem;
    cw_wb_t              cw_wb;
    pcmux_sel_t          pcmux_sel;

    // mirrors of the dut control registers
    ctrl_word_t  m_exe;
    cw_mem_t     m_mem;
    cw_wb_t      m_mem_wb;
    cw_wb_t      m_wb;
    logic        illegal_in_exe;
    logic [31:0] rng_state;
    // decode cases that reached exe
    // opcode index 9 stands for any illegal opcode
    logic [9:0]  seen_op;
    logic [7:0]  seen_f3;
    logic [1:0]  seen_alt;

    `include "ctrl_model.svh"

    pipe_ctrl_top pipe_ctrl_top_i (
        .clk           (clk),
        .rst           (rst),
        .i_stage_valid (stage_valid),
        .i_stage_ready (stage_ready),
        .i_opcode      (opcode),
        .i_funct3      (funct3),
        .i_funct7      (funct7),
        .i_br_en       (br_en),
        .o_ld          (ld),
        .o_cw_exe      (cw_exe),
        .o_cw_mem      (cw_mem),
        .o_cw_wb       (cw_wb),
        .o_pcmux_sel   (pcmux_sel)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic opcode_t legal_opcode(input int idx);
        opcode_t op;
        case (idx)
            0:       op = op_lui;
            1:       op = op_auipc;
            2:       op = op_jal;
            3:       op = op_jalr;
            4:       op = op_br;
            5:       op = op_load;
            6:       op = op_store;
            7:       op = op_imm;
            default: op = op_reg;
        endcase
        return op;
    endfunction

    function automatic int opcode_index(input opcode_t op);
        int idx;
        idx = 9;
        for (int i = 0; i < 9; i++) begin
            if (legal_opcode(i) == op) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // new random inputs for the next cycle
    task automatic drive_inputs();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        stage_vec_t  v;
        stage_vec_t  rdy;
        opcode_t     op;
        rng_state = xorshift32(rng_state);
        r1 = rng_state;
        rng_state = xorshift32(rng_state);
        r2 = rng_state;
        rng_state = xorshift32(rng_state);
        r3 = rng_state;
        // valid 7 in 8 and ready 13 in 16
        for (int k = 0; k < N_STAGES; k++) begin
            v[k]   = (r1[3*k +: 3] != 3'b000);
            rdy[k] = (r2[4*k +: 4] < 4'd13);
        end
        // bit 0 clear never matches an rv32i major opcode
        if (r3[3:0] == 4'd0) begin
            op = opcode_t'({r3[10:5], 1'b0});
        end else begin
            op = legal_opcode(int'(r3[31:16]) % 9);
        end
        stage_valid <= v;
        stage_ready <= rdy;
        opcode      <= op;
        funct3      <= r1[18:16];
        funct7      <= r1[31:25];
        br_en       <= r2[24];
    endtask

    // model registers take the inputs of the cycle just ended
    task automatic advance_model();
        preg_vec_t  ld_m;
        preg_vec_t  bub_m;
        ctrl_word_t dec_m;
        logic       take;
        ld_m  = model_ld(rst, stage_valid, stage_ready);
        bub_m = model_bubble(stage_valid, stage_ready);
        dec_m = model_decode(opcode, funct3, funct7);
        if (rst) begin
            m_exe          = CW_DEFAULT;
            m_mem          = CW_DEFAULT.mem;
            m_mem_wb       = CW_DEFAULT.wb;
            m_wb           = CW_DEFAULT.wb;
            illegal_in_exe = 1'b0;
        end else begin
            // downstream first so each register sees the old upstream word
            if (ld_m[PR_MEM_WB]) begin
                m_wb = bub_m[PR_MEM_WB] ? CW_DEFAULT.wb : m_mem_wb;
            end
            if (ld_m[PR_EXE_MEM]) begin
                m_mem    = bub_m[PR_EXE_MEM] ? CW_DEFAULT.mem : m_exe.mem;
                m_mem_wb = bub_m[PR_EXE_MEM] ? CW_DEFAULT.wb : m_exe.wb;
            end
            if (ld_m[PR_DE_EXE]) begin
                take           = !bub_m[PR_DE_EXE];
                m_exe          = take ? dec_m : CW_DEFAULT;
                illegal_in_exe = take && (opcode_index(opcode) == 9);
                if (take) begin
                    seen_op[opcode_index(opcode)]   = 1'b1;
                    seen_f3[funct3]                 = 1'b1;
                    seen_alt[funct7[FUNCT7_ALT_BIT]] = 1'b1;
                end
            end
        end
    endtask

    task automatic check_outputs();
        if (rst) begin
            check_value("o_ld in reset", 32'(ld), 32'd0);
        end else begin
            check_value("o_ld", 32'(ld), 32'(model_ld(rst, stage_valid, stage_ready)));
        end
        // illegal opcode must look like a nop
        if (illegal_in_exe) begin
            check_value("o_cw_exe after illegal opcode", 32'(cw_exe), 32'(CW_DEFAULT.exe));
        end else begin
            check_value("o_cw_exe", 32'(cw_exe), 32'(m_exe.exe));
        end
        check_value("o_cw_mem", 32'(cw_mem), 32'(m_mem));
        check_value("o_cw_wb", 32'(cw_wb), 32'(m_wb));
        check_value("o_pcmux_sel", 32'(pcmux_sel), 32'(model_pcsel(m_exe.pc_kind, br_en)));
    endtask

    // nothing in flight right after reset
    task automatic check_reset_state();
        check_value("o_cw_mem after reset", 32'(cw_mem), 32'd0);
        check_value("o_cw_wb.ld_reg after reset", 32'(cw_wb.ld_reg), 32'd0);
        check_value("o_pcmux_sel after reset", 32'(pcmux_sel), 32'(pcmux_pc_plus4));
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst            = 1'b1;
        stage_valid    = '0;
        stage_ready    = '0;
        opcode         = op_lui;
        funct3         = '0;
        funct7         = '0;
        br_en          = 1'b0;
        rng_state      = SEED;
        m_exe          = CW_DEFAULT;
        m_mem          = CW_DEFAULT.mem;
        m_mem_wb       = CW_DEFAULT.wb;
        m_wb           = CW_DEFAULT.wb;
        illegal_in_exe = 1'b0;
        seen_op        = '0;
        seen_f3        = '0;
        seen_alt       = '0;
        for (int cyc = 0; cyc < RESET_CYCLES + N_CYCLES; cyc++) begin
            @(posedge clk);
            advance_model();
            drive_inputs();
            if (cyc == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            if (cyc == RESET_CYCLES - 1) begin
                check_reset_state();
            end
            check_outputs();
        end
        if (seen_op == '1 && seen_f3 == '1 && seen_alt == '1) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("decode cases missed: opcodes %b funct3 %b funct7 bit 5 %b",
                     seen_op, seen_f3, seen_alt);
            $display("ERRORS FOUND");
            $fatal(1, "stimulus did not reach every decode case");
        end
    end

endmodule

/* hdl/pipe_ctrl_top.sv */
// pipeline control unit top level
// stall control, instruction decoder and control-word pipe

`timescale 1ns/1ps

module pipe_ctrl_top import rv32i_pkg::*, ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  stage_vec_t           i_stage_valid,
    input  stage_vec_t           i_stage_ready,
    input  opcode_t              i_opcode,
    input  logic [FUNCT3_W-1:0]  i_funct3,
    input  logic [FUNCT7_W-1:0]  i_funct7,
    input  logic                 i_br_en,
    output preg_vec_t            o_ld,
    output cw_exe_t              o_cw_exe,
    output cw_mem_t              o_cw_mem,
    output cw_wb_t               o_cw_wb,
    output pcmux_sel_t           o_pcmux_sel
);

    pipe_ctl_t  pipe_ctl;
    ctrl_word_t dec_cw;

    stall_ctrl stall_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .i_stage_valid (i_stage_valid),
        .i_stage_ready (i_stage_ready),
        .o_pipe_ctl    (pipe_ctl)
    );

    instr_decoder instr_decoder_i (
        .i_opcode (i_opcode),
        .i_funct3 (i_funct3),
        .i_funct7 (i_funct7),
        .o_cw     (dec_cw)
    );

    cw_pipe cw_pipe_i (
        .clk         (clk),
        .rst         (rst),
        .i_pipe_ctl  (pipe_ctl),
        .i_dec_cw    (dec_cw),
        .i_br_en     (i_br_en),
        .o_cw_exe    (o_cw_exe),
        .o_cw_mem    (o_cw_mem),
        .o_cw_wb     (o_cw_wb),
        .o_pcmux_sel (o_pcmux_sel)
    );

    // datapath register enables, same cycle as valid/ready
    assign o_ld = pipe_ctl.ld;

endmodule

/* hdl/cw_pipe.sv */
// control-word pipeline
// exe, mem and wb control registers with bubble insertion, next-pc select

`timescale 1ns/1ps

module cw_pipe import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pipe_ctl_t  i_pipe_ctl,
    input  ctrl_word_t i_dec_cw,
    input  logic       i_br_en,
    output cw_exe_t    o_cw_exe,
    output cw_mem_t    o_cw_mem,
    output cw_wb_t     o_cw_wb,
    output pcmux_sel_t o_pcmux_sel
);

    // de_exe register, full word
    ctrl_word_t exe_q;
    // exe_mem register, mem and wb parts
    cw_mem_t    mem_mem_q;
    cw_wb_t     mem_wb_q;
    // mem_wb register, wb part only
    cw_wb_t     wb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_q     <= CW_DEFAULT;
            mem_mem_q <= CW_DEFAULT.mem;
            mem_wb_q  <= CW_DEFAULT.wb;
            wb_q      <= CW_DEFAULT.wb;
        end else begin
            // decode to exe
            if (i_pipe_ctl.ld[PR_DE_EXE]) begin
                exe_q <= i_pipe_ctl.bubble[PR_DE_EXE] ? CW_DEFAULT : i_dec_cw;
            end
            // exe to mem
            if (i_pipe_ctl.ld[PR_EXE_MEM]) begin
                if (i_pipe_ctl.bubble[PR_EXE_MEM]) begin
                    mem_mem_q <= CW_DEFAULT.mem;
                    mem_wb_q  <= CW_DEFAULT.wb;
                end else begin
                    mem_mem_q <= exe_q.mem;
                    mem_wb_q  <= exe_q.wb;
                end
            end
            // mem to wb
            if (i_pipe_ctl.ld[PR_MEM_WB]) begin
                wb_q <= i_pipe_ctl.bubble[PR_MEM_WB] ? CW_DEFAULT.wb : mem_wb_q;
            end
        end
    end

    assign o_cw_exe = exe_q.exe;
    assign o_cw_mem = mem_mem_q;
    assign o_cw_wb  = wb_q;

    // next pc from the word in exe
    always_comb begin
        case (exe_q.pc_kind)
            pc_jump:     o_pcmux_sel = pcmux_alu_out;
            pc_jump_reg: o_pcmux_sel = pcmux_alu_mod2;
            // taken branch uses the alu target
            pc_branch:   o_pcmux_sel = i_br_en ? pcmux_alu_out : pcmux_pc_plus4;
            default:     o_pcmux_sel = pcmux_pc_plus4;
        endcase
    end

    // decoder and bubbles never mix a load and a store in one word
    assert property (@(posedge clk) disable iff (rst)
        !(mem_mem_q.mem_read && mem_mem_q.mem_write))
        else $error("mem stage word has both read and write set");

endmodule

/* hdl/instr_decoder.sv */
// instruction decoder
// opcode, funct3 and funct7 to the full pipeline control word

`timescale 1ns/1ps

module instr_decoder import rv32i_pkg::*, ctrl_pkg::*; (
    input  opcode_t              i_opcode,
    input  logic [FUNCT3_W-1:0]  i_funct3,
    input  logic [FUNCT7_W-1:0]  i_funct7,
    output ctrl_word_t           o_cw
);

    // sub / sra select
    logic          alt;
    // funct3 viewed per instruction group
    arith_funct3_t arith_f3;
    load_funct3_t  load_f3;

    assign alt      = i_funct7[FUNCT7_ALT_BIT];
    assign arith_f3 = arith_funct3_t'(i_funct3);
    assign load_f3  = load_funct3_t'(i_funct3);

    always_comb begin
        o_cw = CW_DEFAULT;
        case (i_opcode)
            op_lui: begin
                o_cw.wb.ld_reg         = 1'b1;
                o_cw.wb.regfilemux_sel = regfilemux_u_imm;
            end

            op_auipc: begin
                o_cw.exe.alumux1_sel   = alumux1_pc_out;
                o_cw.exe.alumux2_sel   = alumux2_u_imm;
                o_cw.wb.ld_reg         = 1'b1;
            end

            op_jal: begin
                // target pc+j_imm, link pc+4
                o_cw.exe.alumux1_sel   = alumux1_pc_out;
                o_cw.exe.alumux2_sel   = alumux2_j_imm;
                o_cw.wb.ld_reg         = 1'b1;
                o_cw.wb.regfilemux_sel = regfilemux_pc_plus4;
                o_cw.pc_kind           = pc_jump;
            end

            op_jalr: begin
                // target rs1+i_imm, low bit cleared in the pc mux
                o_cw.exe.alumux2_sel   = alumux2_i_imm;
                o_cw.wb.ld_reg         = 1'b1;
                o_cw.wb.regfilemux_sel = regfilemux_pc_plus4;
                o_cw.pc_kind           = pc_jump_reg;
            end

            op_br: begin
                // alu forms the target, comparator decides taken
                o_cw.exe.alumux1_sel = alumux1_pc_out;
                o_cw.exe.alumux2_sel = alumux2_b_imm;
                o_cw.exe.cmpop       = branch_funct3_t'(i_funct3);
                o_cw.pc_kind         = pc_branch;
            end

            op_load: begin
                o_cw.mem.mem_read = 1'b1;
                o_cw.wb.ld_reg    = 1'b1;
                // width and sign extension chosen at writeback
                case (load_f3)
                    lb:  o_cw.wb.regfilemux_sel = regfilemux_lb;
                    lh:  o_cw.wb.regfilemux_sel = regfilemux_lh;
                    lw:  o_cw.wb.regfilemux_sel = regfilemux_lw;
                    lbu: o_cw.wb.regfilemux_sel = regfilemux_lbu;
                    lhu: o_cw.wb.regfilemux_sel = regfilemux_lhu;
                    // reserved width, treat as nop
                    default: o_cw = CW_DEFAULT;
                endcase
            end

            op_store: begin
                o_cw.exe.alumux2_sel = alumux2_s_imm;
                o_cw.mem.mem_write   = 1'b1;
            end

            op_imm, op_reg: begin
                o_cw.wb.ld_reg = 1'b1;
                // second operand is the immediate or rs2
                if (i_opcode == op_imm) begin
                    o_cw.exe.alumux2_sel = alumux2_i_imm;
                    o_cw.exe.cmp_sel     = cmpmux_i_imm;
                end else begin
                    o_cw.exe.alumux2_sel = alumux2_rs2_out;
                    o_cw.exe.cmp_sel     = cmpmux_rs2_out;
                end
                case (arith_f3)
                    arith_add: begin
                        // addi has no sub form
                        if (i_opcode == op_reg && alt) begin
                            o_cw.exe.aluop = alu_sub;
                        end else begin
                            o_cw.exe.aluop = alu_add;
                        end
                    end
                    arith_sll: o_cw.exe.aluop = alu_sll;
                    // set-less-than goes through the comparator
                    arith_slt: begin
                        o_cw.exe.cmpop         = blt;
                        o_cw.wb.regfilemux_sel = regfilemux_br_en;
                    end
                    arith_sltu: begin
                        o_cw.exe.cmpop         = bltu;
                        o_cw.wb.regfilemux_sel = regfilemux_br_en;
                    end
                    arith_xor: o_cw.exe.aluop = alu_xor;
                    arith_sr: begin
                        if (alt) begin
                            o_cw.exe.aluop = alu_sra;
                        end else begin
                            o_cw.exe.aluop = alu_srl;
                        end
                    end
                    arith_or:  o_cw.exe.aluop = alu_or;
                    arith_and: o_cw.exe.aluop = alu_and;
                    default:   o_cw.exe.aluop = alu_add;
                endcase
            end

            // unknown opcode decodes as nop
            default: o_cw = CW_DEFAULT;
        endcase
    end

endmodule

/* hdl/stall_ctrl.sv */
// stall control
// pipeline register load enables and bubble flags from stage valid/ready

`timescale 1ns/1ps

module stall_ctrl import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  stage_vec_t i_stage_valid,
    input  stage_vec_t i_stage_ready,
    output pipe_ctl_t  o_pipe_ctl
);

    // stage holds an instruction it cannot hand on yet
    stage_vec_t stall;
    // bit k set when any stage from k down to wb stalls
    preg_vec_t  stall_below;

    assign stall = i_stage_valid & ~i_stage_ready;

    // suffix or, walking back from writeback
    always_comb begin
        stall_below[ST_WB] = stall[ST_WB];
        for (int k = ST_WB + 1; k < N_PREGS; k++) begin
            stall_below[k] = stall_below[k-1] | stall[k];
        end
    end

    always_comb begin
        o_pipe_ctl = '0;
        if (!rst) begin
            // register feeding stage j freezes on any stall at j or beyond
            o_pipe_ctl.ld[PR_IF_DE]   = ~stall_below[ST_DE];
            o_pipe_ctl.ld[PR_DE_EXE]  = ~stall_below[ST_EXE];
            o_pipe_ctl.ld[PR_EXE_MEM] = ~stall_below[ST_MEM];
            o_pipe_ctl.ld[PR_MEM_WB]  = ~stall_below[ST_WB];
            // nothing to hand on when the feeding stage is stuck or empty
            o_pipe_ctl.bubble[PR_IF_DE]   = stall[ST_IF] | ~i_stage_valid[ST_IF];
            o_pipe_ctl.bubble[PR_DE_EXE]  = stall[ST_DE] | ~i_stage_valid[ST_DE];
            o_pipe_ctl.bubble[PR_EXE_MEM] = stall[ST_EXE] | ~i_stage_valid[ST_EXE];
            o_pipe_ctl.bubble[PR_MEM_WB]  = stall[ST_MEM] | ~i_stage_valid[ST_MEM];
        end
    end

    // a frozen register implies every register in front of it is frozen
    assert property (@(posedge clk) disable iff (rst)
        (~o_pipe_ctl.ld & (o_pipe_ctl.ld >> 1)) == '0)
        else $error("load enables not monotonic %b", o_pipe_ctl.ld);

endmodule

/* hdl/ctrl_pkg.sv */
// pipeline control types
// stage and register vectors, mux selects, ALU ops, control-word structs

package ctrl_pkg;
    import rv32i_pkg::*;

    localparam int N_STAGES = 5;
    localparam int N_PREGS  = 4;

    // stage bit positions, fetch is the MSB
    localparam int ST_IF  = 4;
    localparam int ST_DE  = 3;
    localparam int ST_EXE = 2;
    localparam int ST_MEM = 1;
    localparam int ST_WB  = 0;

    // pipeline register bit positions
    // register k feeds stage k
    localparam int PR_IF_DE   = 3;
    localparam int PR_DE_EXE  = 2;
    localparam int PR_EXE_MEM = 1;
    localparam int PR_MEM_WB  = 0;

    typedef logic [N_STAGES-1:0] stage_vec_t;
    typedef logic [N_PREGS-1:0]  preg_vec_t;

    typedef struct packed {
        preg_vec_t ld;
        preg_vec_t bubble;
    } pipe_ctl_t;

    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_op_t;

    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm,
        alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm,
        regfilemux_lw, regfilemux_pc_plus4, regfilemux_lb,
        regfilemux_lbu, regfilemux_lh, regfilemux_lhu
    } regfilemux_sel_t;

    typedef enum logic [1:0] {pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2} pcmux_sel_t;

    // how the exe stage picks the next pc
    typedef enum logic [1:0] {pc_seq, pc_jump, pc_jump_reg, pc_branch} pc_kind_t;

    typedef struct packed {
        alu_op_t        aluop;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux_sel_t    cmp_sel;
        branch_funct3_t cmpop;
    } cw_exe_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
    } cw_mem_t;

    typedef struct packed {
        logic            ld_reg;
        regfilemux_sel_t regfilemux_sel;
    } cw_wb_t;

    typedef struct packed {
        cw_exe_t  exe;
        cw_mem_t  mem;
        cw_wb_t   wb;
        pc_kind_t pc_kind;
    } ctrl_word_t;

    // nop word, used for bubbles and reset
    localparam ctrl_word_t CW_DEFAULT = '{
        exe: '{aluop: alu_add, alumux1_sel: alumux1_rs1_out, alumux2_sel: alumux2_i_imm,
               cmp_sel: cmpmux_rs2_out, cmpop: beq},
        mem: '{mem_read: 1'b0, mem_write: 1'b0},
        wb: '{ld_reg: 1'b0, regfilemux_sel: regfilemux_alu_out},
        pc_kind: pc_seq
    };

endpackage

/* hdl/rv32i_pkg.sv */
// RV32I instruction-set encodings
// major opcodes, funct3 groups and instruction field widths

package rv32i_pkg;

    // instruction field widths
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    // funct7 bit selecting sub over add and sra over srl
    localparam int FUNCT7_ALT_BIT = 5;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // branch compare kinds, also used for slt/sltu
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // load widths
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // register and immediate arithmetic
    typedef enum logic [2:0] {
        arith_add  = 3'b000,
        arith_sll  = 3'b001,
        arith_slt  = 3'b010,
        arith_sltu = 3'b011,
        arith_xor  = 3'b100,
        arith_sr   = 3'b101,
        arith_or   = 3'b110,
        arith_and  = 3'b111
    } arith_funct3_t;

endpackage
